// ==== logic/la_isa_pkg.sv ====
package la_isa_pkg;

   // data and address width for the 32-bit core
   localparam int xlen = 32;

   // architectural register index
   localparam int reg_idx_w = 5;

   // width of the branch opcode field
   localparam int bru_op_w = 4;

   // branch micro-op opcodes
   // compare ops come first, jumps last
   typedef enum logic [bru_op_w-1:0] {
      // a == 0
      op_eqz,
      // a != 0
      op_nez,
      // a == b
      op_eq,
      // a != b
      op_ne,
      // signed a < b
      op_lt,
      // signed a >= b
      op_ge,
      // unsigned a < b
      op_ltu,
      // unsigned a >= b
      op_geu,
      // indirect jump to a + offset, writes link
      op_jr,
      // relative call, always taken, writes link
      op_bl
   } bru_op_e;

endpackage

// ==== logic/bru_pipe_pkg.sv ====
package bru_pipe_pkg;

   import la_isa_pkg::*;

   // branch lanes per issue packet
   // lane 0 is the oldest in program order
   localparam int num_lanes = 4;

   // lane index width
   localparam int lane_idx_w = $clog2(num_lanes);

   // one branch micro-op as issued to a lane
   typedef struct packed {
      logic                 valid;
      bru_op_e              op;
      // compare operands, a is also the jr base
      logic [xlen-1:0]      a;
      logic [xlen-1:0]      b;
      logic [xlen-1:0]      pc;
      logic [xlen-1:0]      offset;
      // link destination
      logic [reg_idx_w-1:0] rd;
   } bru_uop_t;

   // resolved result of one lane
   typedef struct packed {
      logic                 valid;
      logic                 taken;
      // next fetch address for this branch
      logic [xlen-1:0]      target;
      // return address, aligned pc + 4
      logic [xlen-1:0]      link_pc;
      logic                 link_wen;
      logic [reg_idx_w-1:0] rd;
   } bru_res_t;

   // link register write toward the register file
   typedef struct packed {
      logic                 wen;
      logic [reg_idx_w-1:0] rd;
      logic [xlen-1:0]      data;
   } link_wb_t;

   // front-end redirect request
   typedef struct packed {
      logic                  valid;
      // lane that caused it
      logic [lane_idx_w-1:0] lane;
      logic [xlen-1:0]       pc;
   } redirect_t;

endpackage

// ==== logic/bru_issue_stage.sv ====
module bru_issue_stage (
   input  logic                                                clk,
   input  logic                                                rst_n,
   // incoming packet, sampled every clock
   input  bru_pipe_pkg::bru_uop_t [bru_pipe_pkg::num_lanes-1:0] issue,
   // registered packet toward the lanes
   output bru_pipe_pkg::bru_uop_t [bru_pipe_pkg::num_lanes-1:0] issued
);

   import bru_pipe_pkg::*;

   // payload loads every cycle
   // no stall, so nothing to hold
   // only the valid bits clear on reset
   always_ff @(posedge clk) begin
      issued <= issue;
      if (!rst_n) begin
         for (int i = 0; i < num_lanes; i++) begin
            issued[i].valid <= 1'b0;
         end
      end
   end

endmodule

// ==== logic/branch_unit.sv ====
module branch_unit (
   // one issued branch
   input  bru_pipe_pkg::bru_uop_t uop,
   // its resolution
   output bru_pipe_pkg::bru_res_t res
);

   import la_isa_pkg::*;

   // opcode decode
   logic is_eqz;
   logic is_nez;
   logic is_eq;
   logic is_ne;
   logic is_lt;
   logic is_ge;
   logic is_ltu;
   logic is_geu;
   logic is_jr;
   logic is_bl;

   // condition needs
   logic need_eqx;
   logic need_nex;
   logic need_ltx;
   logic need_gex;
   logic need_eqz;
   logic need_nez;

   // compare results
   logic            compare_unsigned;
   logic            compare_ltx_u;
   logic            compare_ltx_s;
   logic            cond_ltx;
   logic            cond_eqx;
   logic            cond_eqz;
   logic            cond_hold;

   // targets
   logic [xlen-1:0] pc_aligned;
   logic [xlen-1:0] target_next;
   logic [xlen-1:0] target_true;
   logic [xlen-1:0] target_jr;

   assign is_eqz = (uop.op == op_eqz);
   assign is_nez = (uop.op == op_nez);
   assign is_eq  = (uop.op == op_eq);
   assign is_ne  = (uop.op == op_ne);
   assign is_lt  = (uop.op == op_lt);
   assign is_ge  = (uop.op == op_ge);
   assign is_ltu = (uop.op == op_ltu);
   assign is_geu = (uop.op == op_geu);
   assign is_jr  = (uop.op == op_jr);
   assign is_bl  = (uop.op == op_bl);

   // jr and bl need nothing, so they always hold
   assign need_eqx = is_eq;
   assign need_nex = is_ne;
   assign need_ltx = is_lt | is_ltu;
   assign need_gex = is_ge | is_geu;
   assign need_eqz = is_eqz;
   assign need_nez = is_nez;

   // unsigned less-than is the base compare
   assign compare_unsigned = is_ltu | is_geu;
   assign compare_ltx_u    = (uop.a < uop.b);

   // signed from sign bits
   // negative a against positive b is always less
   // same sign falls back to the unsigned result
   assign compare_ltx_s = (uop.a[xlen-1] & ~uop.b[xlen-1])
                        | (compare_ltx_u & (uop.a[xlen-1] == uop.b[xlen-1]));

   assign cond_ltx = compare_unsigned ? compare_ltx_u : compare_ltx_s;
   assign cond_eqx = (uop.a == uop.b);

   // eqz and nez look at a only
   assign cond_eqz = ~|uop.a;

   // every need must be satisfied
   assign cond_hold = (~need_eqz | cond_eqz)
                    & (~need_nez | ~cond_eqz)
                    & (~need_eqx | cond_eqx)
                    & (~need_nex | ~cond_eqx)
                    & (~need_ltx | cond_ltx)
                    & (~need_gex | ~cond_ltx);

   // drop the low two pc bits
   assign pc_aligned  = {uop.pc[xlen-1:2], 2'b00};
   // sequential fetch
   assign target_next = {uop.pc[xlen-1:2] + (xlen-2)'(1), 2'b00};
   // pc-relative taken target
   assign target_true = pc_aligned + uop.offset;
   // register jump target
   assign target_jr   = uop.a + uop.offset;

   always_comb begin
      res.valid = uop.valid;
      // invalid lanes never count as taken
      res.taken = uop.valid & cond_hold;
      if (is_jr) begin
         res.target = target_jr;
      end else if (cond_hold) begin
         res.target = target_true;
      end else begin
         res.target = target_next;
      end
      res.link_pc  = target_next;
      // only jr and bl write the link register
      res.link_wen = uop.valid & (is_jr | is_bl);
      res.rd       = uop.rd;
   end

endmodule

// ==== logic/bru_redirect_select.sv ====
module bru_redirect_select (
   input  logic                                                clk,
   input  logic                                                rst_n,
   // lane results in program order
   input  bru_pipe_pkg::bru_res_t [bru_pipe_pkg::num_lanes-1:0] res,
   // registered redirect toward fetch
   output bru_pipe_pkg::redirect_t                              redirect,
   // registered link writes toward the register file
   output bru_pipe_pkg::link_wb_t [bru_pipe_pkg::num_lanes-1:0] link_wb
);

   import bru_pipe_pkg::*;

   // a taken lane exists in this packet
   logic                  found;
   // index of the oldest taken lane
   logic [lane_idx_w-1:0] first_lane;
   // lanes younger than the oldest taken one
   logic [num_lanes-1:0]  kill;

   // next-state values
   redirect_t                redirect_d;
   link_wb_t [num_lanes-1:0] link_wb_d;

   // program-order scan
   // kill marks every lane after the first taken one
   always_comb begin
      found      = 1'b0;
      first_lane = '0;
      kill       = '0;
      for (int i = 0; i < num_lanes; i++) begin
         kill[i] = found;
         if (res[i].taken && !found) begin
            found      = 1'b1;
            first_lane = lane_idx_w'(i);
         end
      end
   end

   // redirect from the chosen lane, zero when none
   always_comb begin
      redirect_d.valid = found;
      // first_lane stays zero when no lane is taken
      redirect_d.lane  = first_lane;
      redirect_d.pc    = found ? res[first_lane].target : '0;
   end

   // link writes survive only at or before the redirect lane
   // the redirecting lane keeps its own write
   always_comb begin
      for (int i = 0; i < num_lanes; i++) begin
         link_wb_d[i].wen = res[i].link_wen & ~kill[i];
         if (link_wb_d[i].wen) begin
            link_wb_d[i].rd   = res[i].rd;
            link_wb_d[i].data = res[i].link_pc;
         end else begin
            link_wb_d[i].rd   = '0;
            link_wb_d[i].data = '0;
         end
      end
   end

   // output stage
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         redirect <= '0;
         link_wb  <= '0;
      end else begin
         redirect <= redirect_d;
         link_wb  <= link_wb_d;
      end
   end

endmodule

// ==== logic/bru_cluster.sv ====
module bru_cluster (
   input  logic                                                clk,
   input  logic                                                rst_n,
   // issue packet, up to num_lanes branches in program order
   input  bru_pipe_pkg::bru_uop_t [bru_pipe_pkg::num_lanes-1:0] issue,
   // front-end redirect, two cycles after issue
   output bru_pipe_pkg::redirect_t                              redirect,
   // link register writes, same cycle as redirect
   output bru_pipe_pkg::link_wb_t [bru_pipe_pkg::num_lanes-1:0] link_wb
);

   import bru_pipe_pkg::*;

   // registered packet
   bru_uop_t [num_lanes-1:0] issued;

   // per-lane resolutions
   bru_res_t [num_lanes-1:0] res;

   // stage one, capture the packet
   bru_issue_stage bru_issue_stage_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .issue  (issue),
      .issued (issued)
   );

   // combinational lanes, one per packet slot
   for (genvar i = 0; i < num_lanes; i++) begin : g_lane
      branch_unit branch_unit_i (
         .uop (issued[i]),
         .res (res[i])
      );
   end

   // stage two, pick the oldest taken lane and register
   bru_redirect_select bru_redirect_select_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .res      (res),
      .redirect (redirect),
      .link_wb  (link_wb)
   );

endmodule

// ==== verif/bru_cluster_sva.sv ====
module bru_cluster_sva (
   input logic                                                clk,
   input logic                                                rst_n,
   input bru_pipe_pkg::redirect_t                              redirect,
   input bru_pipe_pkg::link_wb_t [bru_pipe_pkg::num_lanes-1:0] link_wb
);

   import bru_pipe_pkg::*;

   // failed assertion count, read by the testbench at the end
   int fail_count = 0;

   // all link write enables
   logic [num_lanes-1:0] wen_vec;
   // enables of lanes younger than the redirect lane
   logic [num_lanes-1:0] younger_wen;

   always_comb begin
      for (int i = 0; i < num_lanes; i++) begin
         wen_vec[i]     = link_wb[i].wen;
         younger_wen[i] = link_wb[i].wen && (i > int'(redirect.lane));
      end
   end

   // idle outputs the cycle after any reset cycle
   assert property (@(posedge clk) !rst_n |=> !redirect.valid && wen_vec == '0)
      else begin
         fail_count++;
         $error("redirect or link write active after reset");
      end

   // no writeback from a killed lane
   assert property (@(posedge clk) disable iff (!rst_n)
                    redirect.valid |-> younger_wen == '0)
      else begin
         fail_count++;
         $error("link write from a lane younger than the redirect");
      end

   // pc parked at zero without a redirect
   assert property (@(posedge clk) disable iff (!rst_n)
                    !redirect.valid |-> redirect.pc == '0)
      else begin
         fail_count++;
         $error("redirect pc nonzero while redirect is invalid");
      end

endmodule

bind bru_cluster bru_cluster_sva bru_cluster_sva_i (
   .clk      (clk),
   .rst_n    (rst_n),
   .redirect (redirect),
   .link_wb  (link_wb)
);

// ==== verif/bru_cluster_tb.sv ====
module bru_cluster_tb;

   import la_isa_pkg::*;
   import bru_pipe_pkg::*;

   // run length and watchdog budget
   localparam int num_packets = 3000;
   localparam int timeout     = (num_packets + 20) * 4;

   // one whole packet as driven on issue
   typedef bru_uop_t [num_lanes-1:0] packet_t;

   // expected response for one packet
   typedef struct packed {
      redirect_t                redirect;
      link_wb_t [num_lanes-1:0] link_wb;
   } expect_t;

   logic    clk;
   logic    rst_n;
   packet_t issue;

   redirect_t                redirect;
   link_wb_t [num_lanes-1:0] link_wb;

   // random source state
   logic [31:0] lfsr_state = 32'h82ceb429;

   // statistics
   int checked;
   int redirects;

   bru_cluster bru_cluster_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .issue    (issue),
      .redirect (redirect),
      .link_wb  (link_wb)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         bits       = {bits[30:0], lfsr_state[0]};
      end
      return bits;
   endfunction

   // operands biased toward zero, equal and sign-flipped pairs
   function automatic bru_uop_t random_uop();
      bru_uop_t   u;
      logic [1:0] sel;
      // valid three times out of four
      u.valid = |take_bits(2);
      u.op    = bru_op_e'(4'(take_bits(4) % 10));
      sel     = 2'(take_bits(2));
      u.a     = (sel == 2'd0) ? '0 : take_bits(xlen);
      sel     = 2'(take_bits(2));
      case (sel)
         2'd0: u.b = u.a;
         // signed and unsigned order disagree here
         2'd1: u.b = u.a ^ 32'h8000_0000;
         default: u.b = take_bits(xlen);
      endcase
      // pc left unaligned on purpose
      u.pc     = take_bits(xlen);
      u.offset = take_bits(xlen);
      u.rd     = reg_idx_w'(take_bits(reg_idx_w));
      return u;
   endfunction

   function automatic packet_t random_packet();
      packet_t p;
      for (int i = 0; i < num_lanes; i++) begin
         p[i] = random_uop();
      end
      return p;
   endfunction

   // branch condition straight from the isa rules
   function automatic logic branch_holds(input bru_uop_t u);
      case (u.op)
         op_eqz: return u.a == '0;
         op_nez: return u.a != '0;
         op_eq:  return u.a == u.b;
         op_ne:  return u.a != u.b;
         op_lt:  return $signed(u.a) < $signed(u.b);
         op_ge:  return $signed(u.a) >= $signed(u.b);
         op_ltu: return u.a < u.b;
         op_geu: return u.a >= u.b;
         // jr and bl
         default: return 1'b1;
      endcase
   endfunction

   // reference model for one packet
   function automatic expect_t predict(input packet_t p);
      expect_t         e;
      logic            found;
      logic [xlen-1:0] aligned;
      e     = '0;
      found = 1'b0;
      for (int i = 0; i < num_lanes; i++) begin
         aligned = {p[i].pc[xlen-1:2], 2'b00};
         // lanes at or before the redirect only
         if (!found && p[i].valid) begin
            if (p[i].op == op_jr || p[i].op == op_bl) begin
               e.link_wb[i].wen  = 1'b1;
               e.link_wb[i].rd   = p[i].rd;
               e.link_wb[i].data = aligned + 32'd4;
            end
            if (branch_holds(p[i])) begin
               found           = 1'b1;
               e.redirect.valid = 1'b1;
               e.redirect.lane  = lane_idx_w'(i);
               if (p[i].op == op_jr) begin
                  e.redirect.pc = p[i].a + p[i].offset;
               end else begin
                  e.redirect.pc = aligned + p[i].offset;
               end
            end
         end
      end
      return e;
   endfunction

   task automatic compare_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      if (expected !== actual) begin
         $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                  $time, name, expected, actual);
         $display("TEST FAIL");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic check_outputs(input expect_t e);
      compare_value("redirect.valid", 64'(e.redirect.valid), 64'(redirect.valid));
      compare_value("redirect.lane", 64'(e.redirect.lane), 64'(redirect.lane));
      compare_value("redirect.pc", 64'(e.redirect.pc), 64'(redirect.pc));
      for (int i = 0; i < num_lanes; i++) begin
         compare_value($sformatf("link_wb[%0d].wen", i),
                       64'(e.link_wb[i].wen), 64'(link_wb[i].wen));
         compare_value($sformatf("link_wb[%0d].rd", i),
                       64'(e.link_wb[i].rd), 64'(link_wb[i].rd));
         compare_value($sformatf("link_wb[%0d].data", i),
                       64'(e.link_wb[i].data), 64'(link_wb[i].data));
      end
   endtask

   initial begin
      packet_t pkt;
      expect_t idle;
      expect_t exp_now;
      expect_t exp_q[$];
      rst_n     = 1'b0;
      issue     = '0;
      idle      = '0;
      checked   = 0;
      redirects = 0;
      // three reset edges, outputs must stay idle
      for (int c = 0; c < 3; c++) begin
         @(posedge clk);
         if (c == 2) begin
            rst_n <= 1'b1;
            issue <= '0;
         end else begin
            // live packets under reset must be dropped
            issue <= random_packet();
         end
         @(negedge clk);
         check_outputs(idle);
      end
      // two packets still in flight from reset
      exp_q.push_back(idle);
      exp_q.push_back(idle);
      // two idle packets at the end drain the pipe
      for (int n = 0; n < num_packets + 2; n++) begin
         @(posedge clk);
         if (n < num_packets) begin
            pkt = random_packet();
         end else begin
            pkt = '0;
         end
         issue <= pkt;
         exp_q.push_back(predict(pkt));
         // outputs settled mid-cycle
         @(negedge clk);
         exp_now = exp_q.pop_front();
         check_outputs(exp_now);
         checked++;
         if (exp_now.redirect.valid) begin
            redirects++;
         end
      end
      $display("%0d packets checked, %0d redirects", checked, redirects);
      if (bru_cluster_i.bru_cluster_sva_i.fail_count != 0 || redirects == 0) begin
         $display("run ended with %0d assertion failures and %0d redirects",
                  bru_cluster_i.bru_cluster_sva_i.fail_count, redirects);
         $display("TEST FAIL");
         $fatal(1, "run ended with failures");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

   // hang guard
   initial begin
      #(timeout);
      $display("watchdog expired before all packets were checked");
      $display("TEST FAIL");
      $fatal(1, "timeout");
   end

endmodule

// ==== vlog.f ====
logic/la_isa_pkg.sv
logic/bru_pipe_pkg.sv
logic/bru_issue_stage.sv
logic/branch_unit.sv
logic/bru_redirect_select.sv
logic/bru_cluster.sv
verif/bru_cluster_sva.sv
verif/bru_cluster_tb.sv
